/* Bender.yml */
package:
  name: read_only_stage

sources:
  - logic/ro_pkg.sv
  - logic/free_list.sv
  - logic/ro_request_splitter.sv
  - logic/ro_thread_context.sv
  - logic/ro_response_unpacker.sv
  - logic/read_only_stage.sv
  - target: test
    files:
      - testbench/read_only_stage_asserts.sv
      - testbench/tb_read_only_stage.sv

/* flist.f */
logic/ro_pkg.sv
logic/free_list.sv
logic/ro_request_splitter.sv
logic/ro_thread_context.sv
logic/ro_response_unpacker.sv
logic/read_only_stage.sv
testbench/read_only_stage_asserts.sv
testbench/tb_read_only_stage.sv

/* logic/free_list.sv */
`timescale 1ns/1ps
`default_nettype none

// circular buffer of free indices, full of every index after reset
module free_list #(
   parameter int  LOG_DEPTH = 3,
   parameter type entry_t   = logic [LOG_DEPTH-1:0]
) (
   input  logic   clk,
   input  logic   rstn,

   input  logic   push,
   input  entry_t push_data,

   input  logic   pop,
   output entry_t pop_data,

   output logic   empty,
   output logic   full
);

   localparam int DEPTH = 2**LOG_DEPTH;

   entry_t               mem [DEPTH];
   logic [LOG_DEPTH-1:0] rd_ptr;
   logic [LOG_DEPTH-1:0] wr_ptr;
   logic [LOG_DEPTH:0]   count;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rd_ptr <= '0;
         wr_ptr <= '0;   // wraps onto rd_ptr, list starts full
         count  <= DEPTH[LOG_DEPTH:0];
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= entry_t'(i);
         end
      end else begin
         if (push) begin
            mem[wr_ptr] <= push_data;
            wr_ptr      <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (push && !pop) count <= count + 1'b1;
         else if (pop && !push) count <= count - 1'b1;
      end
   end

   assign pop_data = mem[rd_ptr];   // oldest free entry
   assign empty    = (count == '0);
   assign full     = (count == DEPTH[LOG_DEPTH:0]);

endmodule

`default_nettype wire

/* logic/read_only_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module read_only_stage #(
   parameter int LOG_ARIDS = 5   // 32 reads in flight
) (
   input  logic             clk,
   input  logic             rstn,

   input  logic             req_valid,
   output logic             req_ready,
   input  ro_pkg::addr_t    req_addr,
   input  ro_pkg::n_words_t req_n_words,
   input  ro_pkg::tag_t     req_tag,

   output logic             arvalid,
   input  logic             arready,
   output ro_pkg::addr_t    araddr,
   output ro_pkg::id_t      arid,

   input  logic             rvalid,
   output logic             rready,
   input  ro_pkg::id_t      rid,
   input  ro_pkg::line_t    rdata,

   output logic             out_valid,
   input  logic             out_ready,
   output ro_pkg::tag_t     out_tag,
   output ro_pkg::word_t    out_data,
   output ro_pkg::n_words_t out_word_id,

   output logic             idle   // every thread back in its list
);

   ro_pkg::thread_id_t thread_id;
   logic               thread_empty;
   logic               thread_pop;
   logic               thread_push;
   ro_pkg::thread_id_t cur_thread;

   ro_pkg::id_t        arid_next;
   logic               arid_empty;
   logic               arid_pop;
   logic               arid_push;
   ro_pkg::id_t        arid_free;

   logic               ctx_load;
   ro_pkg::tag_t       ctx_tag;
   ro_pkg::n_words_t   ctx_n_words;
   logic               consume;
   logic               cur_last;

   logic               mshr_we;
   ro_pkg::id_t        mshr_wid;
   ro_pkg::mshr_t      mshr_wdata;

   free_list #(
      .LOG_DEPTH ($clog2(ro_pkg::N_THREADS)),
      .entry_t   (ro_pkg::thread_id_t)
   ) u_thread_list (
      .clk       (clk),
      .rstn      (rstn),
      .push      (thread_push),
      .push_data (cur_thread),
      .pop       (thread_pop),
      .pop_data  (thread_id),
      .empty     (thread_empty),
      .full      (idle)
   );

   free_list #(
      .LOG_DEPTH (LOG_ARIDS),
      .entry_t   (ro_pkg::id_t)
   ) u_arid_list (
      .clk       (clk),
      .rstn      (rstn),
      .push      (arid_push),
      .push_data (arid_free),
      .pop       (arid_pop),
      .pop_data  (arid_next),
      .empty     (arid_empty),
      .full      ()
   );

   ro_request_splitter #(
      .LOG_ARIDS (LOG_ARIDS)
   ) u_splitter (
      .clk          (clk),
      .rstn         (rstn),
      .req_valid    (req_valid),
      .req_ready    (req_ready),
      .req_addr     (req_addr),
      .req_n_words  (req_n_words),
      .req_tag      (req_tag),
      .thread_id    (thread_id),
      .thread_empty (thread_empty),
      .thread_pop   (thread_pop),
      .ctx_load     (ctx_load),
      .ctx_tag      (ctx_tag),
      .ctx_n_words  (ctx_n_words),
      .arid_next    (arid_next),
      .arid_empty   (arid_empty),
      .arid_pop     (arid_pop),
      .arvalid      (arvalid),
      .arready      (arready),
      .araddr       (araddr),
      .arid         (arid),
      .mshr_we      (mshr_we),
      .mshr_wid     (mshr_wid),
      .mshr_wdata   (mshr_wdata)
   );

   ro_thread_context u_context (
      .clk          (clk),
      .rstn         (rstn),
      .load         (ctx_load),
      .load_thread  (thread_id),
      .load_tag     (ctx_tag),
      .load_n_words (ctx_n_words),
      .consume      (consume),
      .cur_thread   (cur_thread),
      .cur_tag      (out_tag),
      .cur_last     (cur_last)
   );

   ro_response_unpacker #(
      .LOG_ARIDS (LOG_ARIDS)
   ) u_unpacker (
      .clk         (clk),
      .rstn        (rstn),
      .rvalid      (rvalid),
      .rready      (rready),
      .rid         (rid),
      .rdata       (rdata),
      .mshr_we     (mshr_we),
      .mshr_wid    (mshr_wid),
      .mshr_wdata  (mshr_wdata),
      .out_valid   (out_valid),
      .out_ready   (out_ready),
      .out_data    (out_data),
      .out_word_id (out_word_id),
      .cur_thread  (cur_thread),
      .cur_last    (cur_last),
      .consume     (consume),
      .thread_push (thread_push),
      .arid_push   (arid_push),
      .arid_free   (arid_free)
   );

endmodule

`default_nettype wire

/* logic/ro_pkg.sv */
`default_nettype none

package ro_pkg;

   // line geometry
   localparam int LINE_WORDS = 16;   // 32-bit words per cache line
   localparam int N_THREADS  = 8;    // thread contexts

   typedef logic [2:0]   thread_id_t;
   typedef logic [31:0]  word_t;
   typedef logic [31:0]  addr_t;     // byte address
   typedef logic [511:0] line_t;     // one read-data beat

   typedef logic [15:0]  tag_t;      // opaque task tag
   typedef logic [7:0]   n_words_t;  // request length, remaining count, word index
   typedef logic [3:0]   word_idx_t; // word position within a line
   typedef logic [15:0]  word_mask_t;
   typedef logic [7:0]   id_t;       // read id on the memory channels

   // what one outstanding read covers
   typedef struct packed {
      thread_id_t thread;
      word_mask_t valid_words;   // words of the line that belong to the request
      n_words_t   start_word;    // request-relative index of the first of them
   } mshr_t;

endpackage

`default_nettype wire

/* logic/ro_request_splitter.sv */
`timescale 1ns/1ps
`default_nettype none

module ro_request_splitter #(
   parameter int LOG_ARIDS = 5
) (
   input  logic               clk,
   input  logic               rstn,

   input  logic               req_valid,
   output logic               req_ready,
   input  ro_pkg::addr_t      req_addr,
   input  ro_pkg::n_words_t   req_n_words,
   input  ro_pkg::tag_t       req_tag,

   input  ro_pkg::thread_id_t thread_id,
   input  logic               thread_empty,
   output logic               thread_pop,

   output logic               ctx_load,
   output ro_pkg::tag_t       ctx_tag,
   output ro_pkg::n_words_t   ctx_n_words,

   input  ro_pkg::id_t        arid_next,
   input  logic               arid_empty,
   output logic               arid_pop,

   output logic               arvalid,
   input  logic               arready,
   output ro_pkg::addr_t      araddr,
   output ro_pkg::id_t        arid,

   output logic               mshr_we,
   output ro_pkg::id_t        mshr_wid,
   output ro_pkg::mshr_t      mshr_wdata
);

   logic               busy;        // a request is being split
   ro_pkg::addr_t      cur_addr;
   ro_pkg::n_words_t   rem_words;
   ro_pkg::n_words_t   start_idx;   // request index of the word at cur_addr
   ro_pkg::thread_id_t cur_thread;

   ro_pkg::word_idx_t  line_off;
   logic [4:0]         room;        // words left in the current line
   logic [4:0]         n_this;      // words covered by this read
   logic               last_read;
   ro_pkg::word_mask_t wr_mask;
   logic               accept;
   logic               fire;

   assign line_off  = cur_addr[5:2];
   assign room      = 5'(ro_pkg::LINE_WORDS) - {1'b0, line_off};
   assign last_read = (rem_words <= {3'b000, room});
   assign n_this    = last_read ? rem_words[4:0] : room;

   always_comb begin
      wr_mask = '0;
      for (int i = 0; i < ro_pkg::LINE_WORDS; i++) begin
         wr_mask[i] = (i >= line_off) && (i < line_off + n_this);
      end
   end

   assign arvalid = busy && !arid_empty;
   assign araddr  = cur_addr;
   assign arid    = arid_next;
   assign fire    = arvalid && arready;

   // a new request may enter while the final read of the old one goes out
   assign req_ready = !thread_empty && (!busy || (fire && last_read));
   assign accept    = req_valid && req_ready;

   assign thread_pop  = accept;
   assign ctx_load    = accept;
   assign ctx_tag     = req_tag;
   assign ctx_n_words = req_n_words;

   assign arid_pop   = fire;
   assign mshr_we    = fire;
   assign mshr_wid   = arid_next;
   assign mshr_wdata = '{thread: cur_thread, valid_words: wr_mask, start_word: start_idx};

   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy <= 1'b0;
      end else if (accept) begin
         busy <= 1'b1;
      end else if (fire && last_read) begin
         busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         cur_addr   <= req_addr;
         rem_words  <= req_n_words;
         start_idx  <= '0;
         cur_thread <= thread_id;
      end else if (fire && !last_read) begin
         cur_addr  <= {cur_addr[31:6] + 26'd1, 6'd0};   // next line start
         rem_words <= rem_words - ro_pkg::n_words_t'(n_this);
         start_idx <= start_idx + ro_pkg::n_words_t'(n_this);
      end
   end

endmodule

`default_nettype wire

/* logic/ro_response_unpacker.sv */
`timescale 1ns/1ps
`default_nettype none

module ro_response_unpacker #(
   parameter int LOG_ARIDS = 5
) (
   input  logic               clk,
   input  logic               rstn,

   input  logic               rvalid,
   output logic               rready,
   input  ro_pkg::id_t        rid,
   input  ro_pkg::line_t      rdata,

   input  logic               mshr_we,
   input  ro_pkg::id_t        mshr_wid,
   input  ro_pkg::mshr_t      mshr_wdata,

   output logic               out_valid,
   input  logic               out_ready,
   output ro_pkg::word_t      out_data,
   output ro_pkg::n_words_t   out_word_id,

   output ro_pkg::thread_id_t cur_thread,
   input  logic               cur_last,
   output logic               consume,

   output logic               thread_push,
   output logic               arid_push,
   output ro_pkg::id_t        arid_free
);

   ro_pkg::mshr_t      mshr_mem [2**LOG_ARIDS];

   logic               held;          // a beat is being unpacked
   ro_pkg::line_t      data_q;
   ro_pkg::word_mask_t mask_q;        // words still to send
   ro_pkg::n_words_t   word_id_q;
   ro_pkg::thread_id_t thread_q;

   ro_pkg::mshr_t      rd_entry;
   ro_pkg::word_idx_t  low_idx;
   ro_pkg::word_mask_t next_mask;
   logic               accept;
   logic               xfer;

   always_ff @(posedge clk) begin
      if (mshr_we) begin
         mshr_mem[mshr_wid[LOG_ARIDS-1:0]] <= mshr_wdata;
      end
   end

   assign rd_entry = mshr_mem[rid[LOG_ARIDS-1:0]];

   // lowest pending word of the beat
   always_comb begin
      low_idx = '0;
      for (int i = ro_pkg::LINE_WORDS-1; i >= 0; i--) begin
         if (mask_q[i]) low_idx = ro_pkg::word_idx_t'(i);
      end
   end

   assign next_mask = mask_q & (mask_q - 1'b1);   // drop lowest set bit

   assign out_valid   = held;
   assign out_data    = data_q[low_idx*32 +: 32];
   assign out_word_id = word_id_q;
   assign xfer        = out_valid && out_ready;

   assign rready = !held || (xfer && (next_mask == '0));
   assign accept = rvalid && rready;

   assign cur_thread  = thread_q;
   assign consume     = xfer;
   assign thread_push = xfer && cur_last;
   assign arid_push   = accept;      // entry is already captured with the beat
   assign arid_free   = rid;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         held <= 1'b0;
      end else if (accept) begin
         held <= 1'b1;
      end else if (xfer && (next_mask == '0)) begin
         held <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         data_q    <= rdata;
         mask_q    <= rd_entry.valid_words;
         word_id_q <= rd_entry.start_word;
         thread_q  <= rd_entry.thread;
      end else if (xfer) begin
         mask_q    <= next_mask;
         word_id_q <= word_id_q + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* logic/ro_thread_context.sv */
`timescale 1ns/1ps
`default_nettype none

module ro_thread_context (
   input  logic               clk,
   input  logic               rstn,

   input  logic               load,
   input  ro_pkg::thread_id_t load_thread,
   input  ro_pkg::tag_t       load_tag,
   input  ro_pkg::n_words_t   load_n_words,

   input  logic               consume,
   input  ro_pkg::thread_id_t cur_thread,
   output ro_pkg::tag_t       cur_tag,
   output logic               cur_last
);

   ro_pkg::tag_t     tag_mem   [ro_pkg::N_THREADS];
   ro_pkg::n_words_t remaining [ro_pkg::N_THREADS];

   always_ff @(posedge clk) begin
      if (load) begin
         tag_mem[load_thread] <= load_tag;
      end
   end

   // load only hits a free thread and consume only a busy one
   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < ro_pkg::N_THREADS; i++) begin
            remaining[i] <= '0;
         end
      end else begin
         if (load) begin
            remaining[load_thread] <= load_n_words;
         end
         if (consume) begin
            remaining[cur_thread] <= remaining[cur_thread] - 1'b1;
         end
      end
   end

   assign cur_tag  = tag_mem[cur_thread];
   assign cur_last = (remaining[cur_thread] == ro_pkg::n_words_t'(1)); // word being sent ends it

endmodule

`default_nettype wire

/* testbench/read_only_stage_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module read_only_stage_asserts (
   input logic             clk,
   input logic             rstn,
   input logic             arvalid,
   input logic             arready,
   input ro_pkg::addr_t    araddr,
   input logic             out_valid,
   input logic             out_ready,
   input ro_pkg::tag_t     out_tag,
   input ro_pkg::word_t    out_data,
   input ro_pkg::n_words_t out_word_id,
   input logic             idle
);

   int fail_count = 0;   // assertion failures so far

   property ar_held;
      @(posedge clk) disable iff (!rstn)
         arvalid && !arready |=> arvalid && $stable(araddr);
   endproperty

   property out_held;
      @(posedge clk) disable iff (!rstn)
         out_valid && !out_ready |=> out_valid && $stable(out_data)
                                     && $stable(out_word_id) && $stable(out_tag);
   endproperty

   // a word on the output always belongs to a busy thread
   property no_out_when_idle;
      @(posedge clk) disable iff (!rstn) out_valid |-> !idle;
   endproperty

   assert property (ar_held) else begin
      $error("arvalid or araddr changed before arready");
      fail_count++;
   end

   assert property (out_held) else begin
      $error("output word changed or dropped before out_ready");
      fail_count++;
   end

   assert property (no_out_when_idle) else begin
      $error("out_valid high while the stage reports idle");
      fail_count++;
   end

endmodule

bind read_only_stage read_only_stage_asserts u_asserts (.*);

`default_nettype wire

/* testbench/tb_read_only_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_read_only_stage;

   localparam int TIMEOUT = 4000;   // cycles allowed per wait

   logic             clk;
   logic             rstn;
   logic             req_valid;
   logic             req_ready;
   ro_pkg::addr_t    req_addr;
   ro_pkg::n_words_t req_n_words;
   ro_pkg::tag_t     req_tag;
   logic             arvalid;
   logic             arready;
   ro_pkg::addr_t    araddr;
   ro_pkg::id_t      arid;
   logic             rvalid;
   logic             rready;
   ro_pkg::id_t      rid;
   ro_pkg::line_t    rdata;
   logic             out_valid;
   logic             out_ready;
   ro_pkg::tag_t     out_tag;
   ro_pkg::word_t    out_data;
   ro_pkg::n_words_t out_word_id;
   logic             idle;

   integer seed = 14651;
   int     mismatches = 0;
   int     other_errors = 0;
   int     pick;

   logic scramble = 1'b0;       // answer reads in random order
   logic ar_throttle = 1'b0;
   logic out_throttle = 1'b0;
   logic out_hold = 1'b0;       // client refuses every word
   logic r_taken = 1'b0;

   ro_pkg::addr_t    pend_addr [$];   // reads waiting for their beat
   ro_pkg::id_t      pend_id [$];
   ro_pkg::addr_t    ar_log [$];
   ro_pkg::tag_t     rx_tag [$];
   ro_pkg::n_words_t rx_idx [$];
   ro_pkg::word_t    rx_data [$];
   ro_pkg::addr_t    rec_addr [$];    // accepted requests
   ro_pkg::n_words_t rec_n [$];
   ro_pkg::tag_t     rec_tag [$];

   read_only_stage #(.LOG_ARIDS(5)) DUT (.*);

   always #2 clk = ~clk;

   // word i of a line holds its own byte address
   function automatic ro_pkg::line_t make_line(input ro_pkg::addr_t a);
      ro_pkg::line_t l;
      ro_pkg::addr_t base;
      base = a & 32'hFFFF_FFC0;
      for (int i = 0; i < ro_pkg::LINE_WORDS; i++) begin
         l[i*32 +: 32] = base + 32'(4 * i);
      end
      return l;
   endfunction

   // id still owned by a read whose beat was not accepted yet
   function automatic logic id_outstanding(input ro_pkg::id_t id);
      logic found;
      found = rvalid && (rid == id);
      foreach (pend_id[q]) begin
         if (pend_id[q] == id) found = 1'b1;
      end
      return found;
   endfunction

   always @(posedge clk) begin
      if (rstn) begin
         if (arvalid && arready) begin
            if (id_outstanding(arid)) begin
               $display("ERROR: read id %0d issued again before its beat returned", arid);
               other_errors++;
            end
            pend_addr.push_back(araddr);
            pend_id.push_back(arid);
            ar_log.push_back(araddr);
         end
         if (rvalid && rready) r_taken = 1'b1;
         if (out_valid && out_ready) begin
            rx_tag.push_back(out_tag);
            rx_idx.push_back(out_word_id);
            rx_data.push_back(out_data);
         end
      end
   end

   // memory responder and client ready
   always @(negedge clk) begin
      if (r_taken) begin
         rvalid = 1'b0;
         r_taken = 1'b0;
      end
      if (!rvalid && pend_addr.size() > 0) begin
         pick = scramble ? int'($unsigned($random(seed)) % pend_addr.size()) : 0;
         rid = pend_id[pick];
         rdata = make_line(pend_addr[pick]);
         rvalid = 1'b1;
         pend_addr.delete(pick);
         pend_id.delete(pick);
      end
      arready = ar_throttle ? 1'($random(seed)) : 1'b1;
      out_ready = !out_hold && (out_throttle ? 1'($random(seed)) : 1'b1);
   end

   task automatic compare_word(input ro_pkg::word_t got, input ro_pkg::word_t exp,
                               input string msg);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
         mismatches++;
      end
   endtask

   task automatic compare_tag(input ro_pkg::tag_t got, input ro_pkg::tag_t exp,
                              input string msg);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
         mismatches++;
      end
   endtask

   task automatic compare_idx(input ro_pkg::n_words_t got, input ro_pkg::n_words_t exp,
                              input string msg);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s got %0d expected %0d", $time, msg, got, exp);
         mismatches++;
      end
   endtask

   task automatic compare_addr(input ro_pkg::addr_t got, input ro_pkg::addr_t exp,
                               input string msg);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
         mismatches++;
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string msg);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s got %b expected %b", $time, msg, got, exp);
         mismatches++;
      end
   endtask

   task automatic start_test();
      ar_log.delete();
      rx_tag.delete();
      rx_idx.delete();
      rx_data.delete();
      rec_addr.delete();
      rec_n.delete();
      rec_tag.delete();
   endtask

   task automatic present_req(input ro_pkg::addr_t addr, input ro_pkg::n_words_t n,
                              input ro_pkg::tag_t tag);
      @(negedge clk);
      req_valid = 1'b1;
      req_addr = addr;
      req_n_words = n;
      req_tag = tag;
   endtask

   task automatic finish_req();
      int   cycles;
      logic accepted;
      cycles = 0;
      accepted = 1'b0;
      while (!accepted && cycles < TIMEOUT) begin
         @(posedge clk);
         accepted = req_ready;
         cycles++;
      end
      if (!accepted) begin
         $display("ERROR: request with tag %h was never accepted", req_tag);
         other_errors++;
      end
      rec_addr.push_back(req_addr);
      rec_n.push_back(req_n_words);
      rec_tag.push_back(req_tag);
      @(negedge clk);
      req_valid = 1'b0;
   endtask

   task automatic send_req(input ro_pkg::addr_t addr, input ro_pkg::n_words_t n,
                           input ro_pkg::tag_t tag);
      present_req(addr, n, tag);
      finish_req();
   endtask

   task automatic wait_words(input int count);
      int cycles;
      cycles = 0;
      while (rx_data.size() < count && cycles < TIMEOUT) begin
         @(posedge clk);
         cycles++;
      end
      if (rx_data.size() < count) begin
         $display("ERROR: only %0d of %0d words arrived in time", rx_data.size(), count);
         other_errors++;
      end
   endtask

   task automatic wait_idle();
      int cycles;
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
      end while (!idle && cycles < TIMEOUT);
      if (!idle) begin
         $display("ERROR: the stage did not return to idle");
         other_errors++;
      end
   endtask

   task automatic wait_out_valid();
      int cycles;
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
      end while (!out_valid && cycles < TIMEOUT);
      if (!out_valid) begin
         $display("ERROR: no output word appeared");
         other_errors++;
      end
   endtask

   // beats of a single request come back in order so word k arrives k-th
   task automatic check_in_order(input ro_pkg::addr_t addr, input int n,
                                 input ro_pkg::tag_t tag);
      if (rx_data.size() != n) begin
         $display("ERROR: %0d words delivered for tag %h, %0d requested",
                  rx_data.size(), tag, n);
         other_errors++;
      end
      for (int k = 0; k < rx_data.size() && k < n; k++) begin
         compare_tag(rx_tag[k], tag, "word tag");
         compare_idx(rx_idx[k], ro_pkg::n_words_t'(k), "word index");
         compare_word(rx_data[k], addr + 32'(4 * k), "word data");
      end
   endtask

   task automatic check_read_addresses(input ro_pkg::addr_t addr, input int n);
      ro_pkg::addr_t a;
      int            rem;
      int            words;
      int            k;
      a = addr;
      rem = n;
      k = 0;
      while (rem > 0) begin
         words = ro_pkg::LINE_WORDS - int'(a[5:2]);
         if (words > rem) words = rem;
         if (k < ar_log.size()) compare_addr(ar_log[k], a, "line read address");
         rem -= words;
         a = (a | 32'h3F) + 32'd1;   // start of the following line
         k++;
      end
      if (ar_log.size() != k) begin
         $display("ERROR: %0d line reads issued, %0d expected", ar_log.size(), k);
         other_errors++;
      end
   endtask

   task automatic check_all_requests();
      logic [255:0] seen [16];
      int           r;
      for (int q = 0; q < 16; q++) seen[q] = '0;
      for (int j = 0; j < rx_data.size(); j++) begin
         r = -1;
         for (int q = 0; q < rec_tag.size(); q++) begin
            if (rec_tag[q] == rx_tag[j]) r = q;
         end
         if (r < 0) begin
            $display("ERROR: word delivered with tag %h that no request used", rx_tag[j]);
            other_errors++;
         end else if (rx_idx[j] >= rec_n[r] || seen[r][rx_idx[j]]) begin
            $display("ERROR: tag %h index %0d out of range or delivered twice",
                     rx_tag[j], rx_idx[j]);
            other_errors++;
         end else begin
            seen[r][rx_idx[j]] = 1'b1;
            compare_word(rx_data[j], rec_addr[r] + 4 * rx_idx[j], "word data");
         end
      end
      for (int q = 0; q < rec_tag.size(); q++) begin
         if ($countones(seen[q]) != rec_n[q]) begin
            $display("ERROR: tag %h is missing words", rec_tag[q]);
            other_errors++;
         end
      end
   endtask

   task automatic test_single_word();
      @(negedge clk);
      check_flag(idle, 1'b1, "idle after reset");
      check_flag(out_valid, 1'b0, "out_valid after reset");
      check_flag(arvalid, 1'b0, "arvalid after reset");
      check_flag(rready, 1'b1, "rready after reset");
      start_test();
      send_req(32'h0000_200C, 8'd1, 16'h00A1);
      wait_words(1);
      wait_idle();
      check_in_order(32'h0000_200C, 1, 16'h00A1);
   endtask

   task automatic test_line_crossing();
      start_test();
      send_req(32'h0001_0038, 8'd20, 16'h0B02);   // 2 + 16 + 2 words
      wait_words(20);
      wait_idle();
      check_in_order(32'h0001_0038, 20, 16'h0B02);
      check_read_addresses(32'h0001_0038, 20);
   endtask

   task automatic test_out_backpressure();
      start_test();
      out_hold = 1'b1;
      send_req(32'h0002_0004, 8'd6, 16'h0C03);
      wait_out_valid();
      repeat (10) begin
         @(posedge clk);
         check_flag(out_valid, 1'b1, "out_valid under back-pressure");
         check_flag(rready, 1'b0, "rready while a beat is held");
         compare_word(out_data, 32'h0002_0004, "held word");
         compare_idx(out_word_id, 8'd0, "held index");
         compare_tag(out_tag, 16'h0C03, "held tag");
      end
      out_hold = 1'b0;
      wait_words(6);
      wait_idle();
      check_in_order(32'h0002_0004, 6, 16'h0C03);
   endtask

   task automatic test_concurrent();
      ro_pkg::addr_t    addr;
      ro_pkg::n_words_t n;
      int               total;
      start_test();
      scramble = 1'b1;
      ar_throttle = 1'b1;
      out_hold = 1'b1;   // no thread can finish yet
      for (int i = 0; i < 12; i++) begin
         @(posedge clk);
         addr = 32'($random(seed)) & 32'h000F_FFFC;
         n = ro_pkg::n_words_t'(1 + $unsigned($random(seed)) % 32);
         present_req(addr, n, ro_pkg::tag_t'(16'h4000 + i));
         if (i == ro_pkg::N_THREADS) begin
            repeat (20) begin
               @(posedge clk);
               if (req_ready) begin
                  $display("ERROR: req_ready high while every thread is busy");
                  other_errors++;
               end
            end
            out_hold = 1'b0;
            out_throttle = 1'b1;
         end
         finish_req();
      end
      total = 0;
      foreach (rec_n[q]) total += rec_n[q];
      wait_words(total);
      wait_idle();
      check_all_requests();
      scramble = 1'b0;
      ar_throttle = 1'b0;
      out_throttle = 1'b0;
   endtask

   task automatic test_after_drain();
      @(negedge clk);
      check_flag(idle, 1'b1, "idle after drain");
      start_test();
      send_req(32'h0003_FFF0, 8'd9, 16'h0E05);
      wait_words(9);
      wait_idle();
      check_in_order(32'h0003_FFF0, 9, 16'h0E05);
      check_read_addresses(32'h0003_FFF0, 9);
   endtask

   initial begin
      clk = 1'b0;
      rstn = 1'b0;
      req_valid = 1'b0;
      req_addr = '0;
      req_n_words = '0;
      req_tag = '0;
      arready = 1'b0;
      rvalid = 1'b0;
      rid = '0;
      rdata = '0;
      out_ready = 1'b0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
      test_single_word();
      test_line_crossing();
      test_out_backpressure();
      test_concurrent();
      test_after_drain();
      $display("errors: %0d mismatches, %0d other, %0d assertion failures",
               mismatches, other_errors, DUT.u_asserts.fail_count);
      if (mismatches + other_errors + DUT.u_asserts.fail_count == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
